// ==== verilog/mips_pkg.sv ====
package mips_pkg;

  localparam int data_width     = 32;
  localparam int reg_addr_width = 5;

  typedef logic [data_width-1:0]     data_t;
  typedef logic [reg_addr_width-1:0] reg_addr_t;
  typedef logic [31:0]               instr_t;
  typedef logic [5:0]                opcode_t;
  typedef logic [5:0]                funct_t;
  typedef logic [1:0]                alu_src_a_t;
  typedef logic [2:0]                alu_op_t;

  // Instruction field positions (lsb of each field)
  localparam int op_lsb    = 26;
  localparam int rs_lsb    = 21;
  localparam int rt_lsb    = 16;
  localparam int rd_lsb    = 11;
  localparam int shamt_lsb = 6;
  localparam int funct_lsb = 0;
  localparam int imm_width = 16;

  localparam opcode_t op_rtype = 6'h00;
  localparam opcode_t op_addi  = 6'h08;
  localparam opcode_t op_andi  = 6'h0c;
  localparam opcode_t op_ori   = 6'h0d;
  localparam opcode_t op_lui   = 6'h0f;

  localparam funct_t fn_sll = 6'h00;
  localparam funct_t fn_srl = 6'h02;
  localparam funct_t fn_add = 6'h20;
  localparam funct_t fn_sub = 6'h22;
  localparam funct_t fn_and = 6'h24;
  localparam funct_t fn_or  = 6'h25;
  localparam funct_t fn_slt = 6'h2a;

  localparam alu_src_a_t src_a_reg   = 2'b00; // Forwarded rs
  localparam alu_src_a_t src_a_shamt = 2'b01;
  localparam alu_src_a_t src_a_zero  = 2'b10;

  localparam logic src_b_reg  = 1'b0;
  localparam logic src_b_imm  = 1'b1;
  localparam logic reg_dst_rt = 1'b0;
  localparam logic reg_dst_rd = 1'b1;

  // ALU operations
  localparam alu_op_t alu_add = 3'd0;
  localparam alu_op_t alu_sub = 3'd1;
  localparam alu_op_t alu_and = 3'd2;
  localparam alu_op_t alu_or  = 3'd3;
  localparam alu_op_t alu_slt = 3'd4;
  localparam alu_op_t alu_sll = 3'd5;
  localparam alu_op_t alu_srl = 3'd6;

endpackage

// ==== verilog/decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 instr_valid,
  input  mips_pkg::instr_t     instr,
  input  mips_pkg::data_t      read_data_1,
  input  mips_pkg::data_t      read_data_2,
  output mips_pkg::reg_addr_t  rs_addr,
  output mips_pkg::reg_addr_t  rt_addr,
  output mips_pkg::reg_addr_t  rs,
  output mips_pkg::reg_addr_t  rt,
  output mips_pkg::reg_addr_t  rd,
  output mips_pkg::data_t      read_data_1_out,
  output mips_pkg::data_t      read_data_2_out,
  output mips_pkg::data_t      sign_extended_imm,
  output mips_pkg::data_t      shamt,
  output mips_pkg::opcode_t    opcode,
  output mips_pkg::funct_t     funct,
  output mips_pkg::alu_src_a_t alu_src_a,
  output logic                 alu_src_b,
  output logic                 reg_dst,
  output logic                 reg_write
);

  logic                            valid_q;
  mips_pkg::instr_t                instr_q;
  logic [mips_pkg::imm_width-1:0]  imm;
  logic                            supported;
  mips_pkg::reg_addr_t             dest;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= instr_valid;
    end
  end

  always_ff @(posedge clk) begin
    instr_q <= instr;
  end

  // Field split
  assign opcode  = instr_q[mips_pkg::op_lsb +: $bits(mips_pkg::opcode_t)];
  assign funct   = instr_q[mips_pkg::funct_lsb +: $bits(mips_pkg::funct_t)];
  assign rs      = instr_q[mips_pkg::rs_lsb +: mips_pkg::reg_addr_width];
  assign rt      = instr_q[mips_pkg::rt_lsb +: mips_pkg::reg_addr_width];
  assign rd      = instr_q[mips_pkg::rd_lsb +: mips_pkg::reg_addr_width];
  assign imm     = instr_q[mips_pkg::imm_width-1:0];
  assign shamt   = {27'b0, instr_q[mips_pkg::shamt_lsb +: 5]};
  assign rs_addr = rs;
  assign rt_addr = rt;

  assign read_data_1_out = read_data_1;
  assign read_data_2_out = read_data_2;

  // Main control
  always_comb begin
    supported         = 1'b1;
    alu_src_a         = mips_pkg::src_a_reg;
    alu_src_b         = mips_pkg::src_b_reg;
    reg_dst           = mips_pkg::reg_dst_rt;
    sign_extended_imm = {{16{imm[15]}}, imm};
    case (opcode)
      mips_pkg::op_rtype: begin
        reg_dst = mips_pkg::reg_dst_rd;
        case (funct)
          mips_pkg::fn_add, mips_pkg::fn_sub, mips_pkg::fn_and,
          mips_pkg::fn_or, mips_pkg::fn_slt: supported = 1'b1;
          mips_pkg::fn_sll, mips_pkg::fn_srl: alu_src_a = mips_pkg::src_a_shamt;
          default: supported = 1'b0;
        endcase
      end
      mips_pkg::op_addi: alu_src_b = mips_pkg::src_b_imm;
      mips_pkg::op_andi, mips_pkg::op_ori: begin
        alu_src_b         = mips_pkg::src_b_imm;
        sign_extended_imm = {16'b0, imm}; // Logic ops zero-extend
      end
      mips_pkg::op_lui: begin
        alu_src_a         = mips_pkg::src_a_zero; // 0 + upper immediate
        alu_src_b         = mips_pkg::src_b_imm;
        sign_extended_imm = {imm, 16'b0};
      end
      default: supported = 1'b0;
    endcase
  end

  assign dest      = (reg_dst == mips_pkg::reg_dst_rd) ? rd : rt;
  // Bubbles, unknown encodings and r0 targets never write
  assign reg_write = valid_q && supported && (dest != '0);

  a_no_write_on_bubble: assert property (@(posedge clk) disable iff (!rst_n)
    !instr_valid |=> !reg_write);

endmodule

// ==== verilog/reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
  input  logic                clk,
  input  logic                rst_n,
  input  mips_pkg::reg_addr_t rs_addr,
  input  mips_pkg::reg_addr_t rt_addr,
  input  mips_pkg::reg_addr_t wr_addr,
  input  logic                wr_en,
  input  mips_pkg::data_t     wr_data,
  output mips_pkg::data_t     read_data_1,
  output mips_pkg::data_t     read_data_2
);

  mips_pkg::data_t regs [32];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en && wr_addr != '0) begin
      regs[wr_addr] <= wr_data;
    end
  end

  // Same-cycle write is bypassed to the readers
  always_comb begin
    if (rs_addr == '0) begin
      read_data_1 = '0;
    end else if (wr_en && wr_addr == rs_addr) begin
      read_data_1 = wr_data;
    end else begin
      read_data_1 = regs[rs_addr];
    end
    if (rt_addr == '0) begin
      read_data_2 = '0;
    end else if (wr_en && wr_addr == rt_addr) begin
      read_data_2 = wr_data;
    end else begin
      read_data_2 = regs[rt_addr];
    end
  end

  // Decode already drops r0 destinations
  a_no_r0_write: assert property (@(posedge clk) disable iff (!rst_n)
    wr_en |-> wr_addr != '0);

endmodule

// ==== verilog/id_ex.sv ====
`timescale 1ns/1ps

module id_ex (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 flush,           // Squash the instruction entering EX
  input  mips_pkg::reg_addr_t  rs_in,
  input  mips_pkg::reg_addr_t  rt_in,
  input  mips_pkg::reg_addr_t  rd_in,
  input  mips_pkg::data_t      read_data_1_in,
  input  mips_pkg::data_t      read_data_2_in,
  input  mips_pkg::data_t      sign_extended_imm_in,
  input  mips_pkg::data_t      shamt_in,
  input  mips_pkg::opcode_t    opcode_in,
  input  mips_pkg::funct_t     funct_in,
  input  mips_pkg::alu_src_a_t alu_src_a_in,
  input  logic                 alu_src_b_in,
  input  logic                 reg_dst_in,
  input  logic                 reg_write_in,
  output mips_pkg::reg_addr_t  rs_out,
  output mips_pkg::reg_addr_t  rt_out,
  output mips_pkg::reg_addr_t  rd_out,
  output mips_pkg::data_t      read_data_1_out,
  output mips_pkg::data_t      read_data_2_out,
  output mips_pkg::data_t      sign_extended_imm_out,
  output mips_pkg::data_t      shamt_out,
  output mips_pkg::opcode_t    opcode_out,
  output mips_pkg::funct_t     funct_out,
  output mips_pkg::alu_src_a_t alu_src_a_out,
  output logic                 alu_src_b_out,
  output logic                 reg_dst_out,
  output logic                 reg_write_out
);

  always_ff @(posedge clk) begin
    if (!rst_n || flush) begin
      // Load a NOP
      rs_out                <= '0;
      rt_out                <= '0;
      rd_out                <= '0;
      read_data_1_out       <= '0;
      read_data_2_out       <= '0;
      sign_extended_imm_out <= '0;
      shamt_out             <= '0;
      opcode_out            <= '0;
      funct_out             <= '0;
      alu_src_a_out         <= mips_pkg::src_a_reg;
      alu_src_b_out         <= mips_pkg::src_b_reg;
      reg_dst_out           <= mips_pkg::reg_dst_rt;
      reg_write_out         <= 1'b0;
    end else begin
      rs_out                <= rs_in;
      rt_out                <= rt_in;
      rd_out                <= rd_in;
      read_data_1_out       <= read_data_1_in;
      read_data_2_out       <= read_data_2_in;
      sign_extended_imm_out <= sign_extended_imm_in;
      shamt_out             <= shamt_in;
      opcode_out            <= opcode_in;
      funct_out             <= funct_in;
      alu_src_a_out         <= alu_src_a_in;
      alu_src_b_out         <= alu_src_b_in;
      reg_dst_out           <= reg_dst_in;
      reg_write_out         <= reg_write_in;
    end
  end

  a_flush_bubble: assert property (@(posedge clk) flush |=> !reg_write_out);

endmodule

// ==== verilog/execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage (
  input  logic                 clk,
  input  logic                 rst_n,
  input  mips_pkg::reg_addr_t  rs,
  input  mips_pkg::reg_addr_t  rt,
  input  mips_pkg::reg_addr_t  rd,
  input  mips_pkg::data_t      read_data_1,
  input  mips_pkg::data_t      read_data_2,
  input  mips_pkg::data_t      sign_extended_imm,
  input  mips_pkg::data_t      shamt,
  input  mips_pkg::opcode_t    opcode,
  input  mips_pkg::funct_t     funct,
  input  mips_pkg::alu_src_a_t alu_src_a,
  input  logic                 alu_src_b,
  input  logic                 reg_dst,
  input  logic                 reg_write,
  output logic                 wb_valid,
  output mips_pkg::reg_addr_t  wb_reg,
  output mips_pkg::data_t      wb_data
);

  mips_pkg::data_t     fwd_a;
  mips_pkg::data_t     fwd_b;
  mips_pkg::data_t     op_a;
  mips_pkg::data_t     op_b;
  mips_pkg::data_t     result;
  mips_pkg::alu_op_t   alu_op;
  mips_pkg::reg_addr_t dest;

  // Distance-one forwarding from the EX/WB latch
  assign fwd_a = (wb_valid && wb_reg != '0 && wb_reg == rs) ? wb_data : read_data_1;
  assign fwd_b = (wb_valid && wb_reg != '0 && wb_reg == rt) ? wb_data : read_data_2;

  always_comb begin
    case (alu_src_a)
      mips_pkg::src_a_reg:   op_a = fwd_a;
      mips_pkg::src_a_shamt: op_a = shamt;
      default:               op_a = '0;
    endcase
  end

  assign op_b = (alu_src_b == mips_pkg::src_b_imm) ? sign_extended_imm : fwd_b;

  // ALU control
  always_comb begin
    alu_op = mips_pkg::alu_add;
    case (opcode)
      mips_pkg::op_rtype: begin
        case (funct)
          mips_pkg::fn_sub: alu_op = mips_pkg::alu_sub;
          mips_pkg::fn_and: alu_op = mips_pkg::alu_and;
          mips_pkg::fn_or:  alu_op = mips_pkg::alu_or;
          mips_pkg::fn_slt: alu_op = mips_pkg::alu_slt;
          mips_pkg::fn_sll: alu_op = mips_pkg::alu_sll;
          mips_pkg::fn_srl: alu_op = mips_pkg::alu_srl;
          default:          alu_op = mips_pkg::alu_add;
        endcase
      end
      mips_pkg::op_andi: alu_op = mips_pkg::alu_and;
      mips_pkg::op_ori:  alu_op = mips_pkg::alu_or;
      default:           alu_op = mips_pkg::alu_add; // ADDI and LUI
    endcase
  end

  always_comb begin
    case (alu_op)
      mips_pkg::alu_sub: result = op_a - op_b;
      mips_pkg::alu_and: result = op_a & op_b;
      mips_pkg::alu_or:  result = op_a | op_b;
      mips_pkg::alu_slt: result = {31'b0, $signed(op_a) < $signed(op_b)};
      mips_pkg::alu_sll: result = op_b << op_a[4:0]; // rt shifted by shamt
      mips_pkg::alu_srl: result = op_b >> op_a[4:0];
      default:           result = op_a + op_b;
    endcase
  end

  assign dest = (reg_dst == mips_pkg::reg_dst_rd) ? rd : rt;

  // EX/WB latch
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wb_valid <= 1'b0;
    end else begin
      wb_valid <= reg_write;
    end
  end

  always_ff @(posedge clk) begin
    wb_reg  <= dest;
    wb_data <= result;
  end

  a_wb_not_r0: assert property (@(posedge clk) disable iff (!rst_n)
    wb_valid |-> wb_reg != '0);

endmodule

// ==== verilog/mips_lite_top.sv ====
`timescale 1ns/1ps

module mips_lite_top (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                instr_valid,
  input  mips_pkg::instr_t    instr,
  input  logic                flush,
  output logic                wb_valid,
  output mips_pkg::reg_addr_t wb_reg,
  output mips_pkg::data_t     wb_data
);

  // Decode side
  mips_pkg::reg_addr_t  rs_addr, rt_addr;
  mips_pkg::data_t      rf_data_1, rf_data_2;
  mips_pkg::reg_addr_t  id_rs, id_rt, id_rd;
  mips_pkg::data_t      id_data_1, id_data_2, id_imm, id_shamt;
  mips_pkg::opcode_t    id_opcode;
  mips_pkg::funct_t     id_funct;
  mips_pkg::alu_src_a_t id_alu_src_a;
  logic                 id_alu_src_b, id_reg_dst, id_reg_write;

  // Execute side
  mips_pkg::reg_addr_t  ex_rs, ex_rt, ex_rd;
  mips_pkg::data_t      ex_data_1, ex_data_2, ex_imm, ex_shamt;
  mips_pkg::opcode_t    ex_opcode;
  mips_pkg::funct_t     ex_funct;
  mips_pkg::alu_src_a_t ex_alu_src_a;
  logic                 ex_alu_src_b, ex_reg_dst, ex_reg_write;

  decode_stage u_decode (
    .clk(clk), .rst_n(rst_n), .instr_valid(instr_valid), .instr(instr),
    .read_data_1(rf_data_1), .read_data_2(rf_data_2),
    .rs_addr(rs_addr), .rt_addr(rt_addr), .rs(id_rs), .rt(id_rt), .rd(id_rd),
    .read_data_1_out(id_data_1), .read_data_2_out(id_data_2),
    .sign_extended_imm(id_imm), .shamt(id_shamt), .opcode(id_opcode), .funct(id_funct),
    .alu_src_a(id_alu_src_a), .alu_src_b(id_alu_src_b), .reg_dst(id_reg_dst),
    .reg_write(id_reg_write)
  );

  reg_file u_reg_file (
    .clk(clk), .rst_n(rst_n), .rs_addr(rs_addr), .rt_addr(rt_addr),
    .wr_addr(wb_reg), .wr_en(wb_valid), .wr_data(wb_data), // Writeback port
    .read_data_1(rf_data_1), .read_data_2(rf_data_2)
  );

  id_ex u_id_ex (
    .clk(clk), .rst_n(rst_n), .flush(flush),
    .rs_in(id_rs), .rt_in(id_rt), .rd_in(id_rd),
    .read_data_1_in(id_data_1), .read_data_2_in(id_data_2),
    .sign_extended_imm_in(id_imm), .shamt_in(id_shamt),
    .opcode_in(id_opcode), .funct_in(id_funct), .alu_src_a_in(id_alu_src_a),
    .alu_src_b_in(id_alu_src_b), .reg_dst_in(id_reg_dst), .reg_write_in(id_reg_write),
    .rs_out(ex_rs), .rt_out(ex_rt), .rd_out(ex_rd),
    .read_data_1_out(ex_data_1), .read_data_2_out(ex_data_2),
    .sign_extended_imm_out(ex_imm), .shamt_out(ex_shamt),
    .opcode_out(ex_opcode), .funct_out(ex_funct), .alu_src_a_out(ex_alu_src_a),
    .alu_src_b_out(ex_alu_src_b), .reg_dst_out(ex_reg_dst), .reg_write_out(ex_reg_write)
  );

  execute_stage u_execute (
    .clk(clk), .rst_n(rst_n), .rs(ex_rs), .rt(ex_rt), .rd(ex_rd),
    .read_data_1(ex_data_1), .read_data_2(ex_data_2),
    .sign_extended_imm(ex_imm), .shamt(ex_shamt), .opcode(ex_opcode), .funct(ex_funct),
    .alu_src_a(ex_alu_src_a), .alu_src_b(ex_alu_src_b), .reg_dst(ex_reg_dst),
    .reg_write(ex_reg_write),
    .wb_valid(wb_valid), .wb_reg(wb_reg), .wb_data(wb_data)
  );

endmodule

// ==== tb/tb_mips_lite.sv ====
`timescale 1ns/1ps

module tb_mips_lite;

  localparam int          num_slots   = 600;
  localparam int          drain_limit = 20;
  localparam logic [31:0] lfsr_seed   = 32'd4;
  localparam logic [31:0] lfsr_taps   = 32'h8020_0003; // x^32 + x^22 + x^2 + x + 1

  logic                clk;
  logic                rst_n;
  logic                instr_valid;
  mips_pkg::instr_t    instr;
  logic                flush;
  logic                wb_valid;
  mips_pkg::reg_addr_t wb_reg;
  mips_pkg::data_t     wb_data;

  logic [31:0]         lfsr_state;
  int                  edge_cnt = 0;
  int                  errors;
  mips_pkg::data_t     model_regs [32]; // Architectural state seen by the reference

  // Expected writebacks in program order
  mips_pkg::reg_addr_t exp_reg_q [$];
  mips_pkg::data_t     exp_data_q [$];
  int                  exp_edge_q [$];

  // Last issued writer, kept so a flush one edge later can undo it
  logic                prev_pushed;
  mips_pkg::reg_addr_t prev_dest;
  mips_pkg::data_t     prev_old;

  mips_lite_top uut (
    .clk(clk), .rst_n(rst_n), .instr_valid(instr_valid), .instr(instr), .flush(flush),
    .wb_valid(wb_valid), .wb_reg(wb_reg), .wb_data(wb_data)
  );

  always #2 clk = ~clk;

  always @(posedge clk) edge_cnt <= edge_cnt + 1;

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ lfsr_taps) : (s >> 1);
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r          = {r[30:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
    return r;
  endfunction

  // ISA behavior of one instruction against model_regs
  function automatic void ref_execute(input mips_pkg::instr_t ins, output logic writes,
                                      output mips_pkg::reg_addr_t dest,
                                      output mips_pkg::data_t value);
    mips_pkg::opcode_t   op;
    mips_pkg::funct_t    fn;
    mips_pkg::reg_addr_t rs;
    mips_pkg::reg_addr_t rt;
    mips_pkg::reg_addr_t rd;
    logic [4:0]          sh;
    logic [15:0]         imm;
    mips_pkg::data_t     a;
    mips_pkg::data_t     b;
    logic                known;
    op    = ins[mips_pkg::op_lsb +: 6];
    fn    = ins[mips_pkg::funct_lsb +: 6];
    rs    = ins[mips_pkg::rs_lsb +: mips_pkg::reg_addr_width];
    rt    = ins[mips_pkg::rt_lsb +: mips_pkg::reg_addr_width];
    rd    = ins[mips_pkg::rd_lsb +: mips_pkg::reg_addr_width];
    sh    = ins[mips_pkg::shamt_lsb +: 5];
    imm   = ins[15:0];
    a     = (rs == 0) ? '0 : model_regs[rs];
    b     = (rt == 0) ? '0 : model_regs[rt];
    known = 1'b1;
    dest  = rt;
    value = '0;
    case (op)
      mips_pkg::op_rtype: begin
        dest = rd;
        case (fn)
          mips_pkg::fn_add: value = a + b;
          mips_pkg::fn_sub: value = a - b;
          mips_pkg::fn_and: value = a & b;
          mips_pkg::fn_or:  value = a | b;
          mips_pkg::fn_slt: value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
          mips_pkg::fn_sll: value = b << sh;
          mips_pkg::fn_srl: value = b >> sh;
          default:          known = 1'b0;
        endcase
      end
      mips_pkg::op_addi: value = a + {{16{imm[15]}}, imm};
      mips_pkg::op_andi: value = a & {16'h0000, imm};
      mips_pkg::op_ori:  value = a | {16'h0000, imm};
      mips_pkg::op_lui:  value = {imm, 16'h0000};
      default:           known = 1'b0;
    endcase
    writes = known && (dest != 0);
  endfunction

  task automatic fail_now(input string why);
    errors++;
    $display("%s at time %0t", why, $time);
    $display("CHECKS FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    if (got !== expected) begin
      errors++;
      $display("FAIL time=%0t %s got=%h expected=%h", $time, name, got, expected);
      $display("CHECKS FAILED");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  // One issue slot, driven just after the rising edge
  task automatic issue_slot();
    logic                do_flush;
    logic                valid;
    logic [3:0]          op_sel;
    logic [2:0]          fn_sel;
    mips_pkg::opcode_t   op;
    mips_pkg::funct_t    fn;
    mips_pkg::reg_addr_t rs;
    mips_pkg::reg_addr_t rt;
    mips_pkg::reg_addr_t rd;
    logic [4:0]          sh;
    logic [15:0]         imm;
    mips_pkg::instr_t    ins;
    logic                writes;
    mips_pkg::reg_addr_t dest;
    mips_pkg::data_t     value;
    do_flush = (rand_bits(4) == 0);
    if (do_flush && prev_pushed) begin // Squash the previous instruction
      void'(exp_reg_q.pop_back());
      void'(exp_data_q.pop_back());
      void'(exp_edge_q.pop_back());
      model_regs[prev_dest] = prev_old;
    end
    prev_pushed = 1'b0;
    op_sel = 4'(rand_bits(4));
    fn_sel = 3'(rand_bits(3));
    rs     = 5'(rand_bits(3)); // r0..r7 keeps dependencies dense
    rt     = 5'(rand_bits(3));
    rd     = 5'(rand_bits(3));
    sh     = 5'(rand_bits(5));
    imm    = 16'(rand_bits(16));
    valid  = (rand_bits(3) != 0);
    case (op_sel)
      4'd7, 4'd8: op = mips_pkg::op_addi;
      4'd9:       op = mips_pkg::op_andi;
      4'd10:      op = mips_pkg::op_ori;
      4'd11:      op = mips_pkg::op_lui;
      4'd12:      op = 6'h23; // Load, unsupported
      4'd13:      op = 6'h04; // Branch, unsupported
      default:    op = mips_pkg::op_rtype;
    endcase
    case (fn_sel)
      3'd0:    fn = mips_pkg::fn_add;
      3'd1:    fn = mips_pkg::fn_sub;
      3'd2:    fn = mips_pkg::fn_and;
      3'd3:    fn = mips_pkg::fn_or;
      3'd4:    fn = mips_pkg::fn_slt;
      3'd5:    fn = mips_pkg::fn_sll;
      3'd6:    fn = mips_pkg::fn_srl;
      default: fn = 6'h08;
    endcase
    if (op == mips_pkg::op_rtype) begin
      ins = {op, rs, rt, rd, sh, fn};
    end else begin
      ins = {op, rs, rt, imm};
    end
    if (valid) begin
      ref_execute(ins, writes, dest, value);
      if (writes) begin
        prev_old         = model_regs[dest];
        model_regs[dest] = value;
        prev_dest        = dest;
        prev_pushed      = 1'b1;
        exp_reg_q.push_back(dest);
        exp_data_q.push_back(value);
        exp_edge_q.push_back(edge_cnt + 3); // Sampled next edge, visible two edges later
      end
    end
    instr_valid = valid;
    instr       = ins;
    flush       = do_flush;
  endtask

  // Compare writebacks mid-cycle when outputs are stable
  always @(negedge clk) begin : compare_wb
    mips_pkg::reg_addr_t er;
    mips_pkg::data_t     ed;
    int                  ee;
    if (rst_n) begin
      if ($isunknown(wb_valid)) begin
        fail_now("wb_valid is unknown after reset");
      end else if (wb_valid) begin
        if (exp_reg_q.size() == 0) begin
          fail_now("writeback seen with no instruction expecting one");
        end else begin
          er = exp_reg_q.pop_front();
          ed = exp_data_q.pop_front();
          ee = exp_edge_q.pop_front();
          check_value("wb_reg", 32'(wb_reg), 32'(er));
          check_value("wb_data", wb_data, ed);
          check_value("writeback edge", edge_cnt, ee);
        end
      end
    end
  end

  initial begin
    int wait_cnt;
    clk         = 1'b0;
    rst_n       = 1'b0;
    instr_valid = 1'b0;
    instr       = '0;
    flush       = 1'b0;
    lfsr_state  = lfsr_seed;
    errors      = 0;
    prev_pushed = 1'b0;
    prev_dest   = '0;
    prev_old    = '0;
    for (int i = 0; i < 32; i++) begin
      model_regs[i] = '0;
    end
    repeat (4) @(posedge clk);
    #0.5;
    rst_n = 1'b1;
    for (int n = 0; n < num_slots; n++) begin
      @(posedge clk);
      #0.5;
      issue_slot();
    end
    @(posedge clk);
    #0.5;
    instr_valid = 1'b0;
    flush       = 1'b0;
    wait_cnt    = 0;
    while (exp_reg_q.size() != 0 && wait_cnt < drain_limit) begin
      @(posedge clk);
      wait_cnt++;
    end
    if (exp_reg_q.size() != 0) begin
      fail_now("timeout waiting for outstanding writebacks");
    end else begin
      repeat (4) @(posedge clk); // Catch any stray writeback
      if (errors == 0) begin
        $display("ALL CHECKS PASSED");
        $finish;
      end else begin
        $display("CHECKS FAILED");
        $fatal(1, "errors were reported");
      end
    end
  end

endmodule

// ==== mips_lite.f ====
verilog/mips_pkg.sv
verilog/decode_stage.sv
verilog/reg_file.sv
verilog/id_ex.sv
verilog/execute_stage.sv
verilog/mips_lite_top.sv
tb/tb_mips_lite.sv
